// File: src/mmu_config.svh
// Width and size macros for the address, page offset, TLB and APB port
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// Linear and physical address width
`define MMU_ADDR_W 32

// 4 KiB pages
`define MMU_PAGE_OFS_W 12

// Direct mapped, indexed by the low VPN bits
`define MMU_TLB_ENTRIES 16

// Byte offsets into the register map
`define MMU_APB_ADDR_W 8

`endif

// File: src/x86_arch_pkg.sv
// Architectural types for CPU mode, descriptor, translation request and response
`include "mmu_config.svh"

package x86_arch_pkg;

    // Encoding follows the legacy mode register
    typedef enum logic [2:0] {
        CPU_MODE_REAL = 3'd0,
        CPU_MODE_PROT = 3'd1,
        CPU_MODE_V86  = 3'd2,
        CPU_MODE_LONG = 3'd3  // Reserved
    } cpu_mode_e;

    // 1 MiB window in real and v86 mode
    localparam logic [`MMU_ADDR_W-1:0] REAL_MODE_LIMIT = 32'h000F_FFFF;

    // Standard 8-byte segment descriptor, MSB first
    typedef struct packed {
        logic [7:0]  base_hi;   // Base 31:24
        logic [3:0]  flags;     // G, D/B, L, AVL
        logic [3:0]  limit_hi;  // Limit 19:16
        logic        present;
        logic [1:0]  dpl;
        logic        s;         // Code or data when set
        logic [3:0]  seg_type;
        logic [7:0]  base_mid;  // Base 23:16
        logic [15:0] base_lo;
        logic [15:0] limit_lo;
    } seg_desc_t;

    typedef struct packed {
        logic [`MMU_ADDR_W-1:0] linear;
        seg_desc_t              desc;
        logic [1:0]             cpl;
    } xlate_req_t;

    typedef struct packed {
        cpu_mode_e              mode;
        logic [`MMU_ADDR_W-1:0] base;
        logic [`MMU_ADDR_W-1:0] limit;
        logic [3:0]             seg_type;
        logic                   segment_valid;
        logic                   privilege_violation;
    } seg_info_t;

    // Passed from the segment stage to the paging stage
    typedef struct packed {
        seg_info_t              seg;
        logic [`MMU_ADDR_W-1:0] linear;
        logic                   paging;  // Protected mode with PG
    } mid_xlate_t;

    typedef struct packed {
        seg_info_t              seg;
        logic [`MMU_ADDR_W-1:0] phys_addr;
        logic                   page_fault;
    } xlate_rsp_t;

    // PE off wins over VM
    function automatic cpu_mode_e mode_decode(input logic pe, input logic vm);
        if (!pe) begin
            return CPU_MODE_REAL;
        end
        return vm ? CPU_MODE_V86 : CPU_MODE_PROT;
    endfunction

endpackage

// File: src/mmu_regs_pkg.sv
// Register map offsets, bit positions, TLB fill and control structs
`include "mmu_config.svh"

package mmu_regs_pkg;

    localparam int APB_DATA_W = 32;
    localparam int VPN_W      = `MMU_ADDR_W - `MMU_PAGE_OFS_W;
    localparam int PFN_W      = `MMU_ADDR_W - `MMU_PAGE_OFS_W;

    localparam logic [`MMU_APB_ADDR_W-1:0] REG_CR0         = 'h00;
    localparam logic [`MMU_APB_ADDR_W-1:0] REG_CTRL        = 'h04;
    localparam logic [`MMU_APB_ADDR_W-1:0] REG_TLB_VPN     = 'h08;
    localparam logic [`MMU_APB_ADDR_W-1:0] REG_TLB_PFN     = 'h0C;  // Write fires the fill
    localparam logic [`MMU_APB_ADDR_W-1:0] REG_STATUS      = 'h10;
    localparam logic [`MMU_APB_ADDR_W-1:0] REG_HIT_COUNT   = 'h14;
    localparam logic [`MMU_APB_ADDR_W-1:0] REG_FAULT_COUNT = 'h18;

    localparam int CR0_PE_BIT     = 0;
    localparam int CR0_PG_BIT     = 31;
    localparam int CTRL_VM_BIT    = 0;
    localparam int CTRL_FLUSH_BIT = 1;   // Self clearing

    // STATUS layout
    localparam int ST_MODE_LSB = 0;      // Three bits of cpu_mode_e
    localparam int ST_PG_BIT   = 3;
    localparam int ST_PE_BIT   = 4;
    localparam int ST_V86_BIT  = 5;

    typedef struct packed {
        logic pe;
        logic pg;
        logic vm_flag;
    } mmu_ctrl_t;

    // One cycle pulse on valid
    typedef struct packed {
        logic             valid;
        logic [VPN_W-1:0] vpn;
        logic [PFN_W-1:0] pfn;
    } tlb_fill_t;

endpackage

// File: src/mmu_csr.sv
// APB register block with CR0, VM flag, TLB fill staging, flush and counters
`include "mmu_config.svh"

module mmu_csr
    import x86_arch_pkg::*;
    import mmu_regs_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`MMU_APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0]      pwdata,
    output logic [APB_DATA_W-1:0]      prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  logic                       rsp_valid,
    input  xlate_rsp_t                 rsp,
    input  logic                       tlb_hit,
    output mmu_ctrl_t                  ctrl,
    output tlb_fill_t                  fill,
    output logic                       flush
);

    logic [APB_DATA_W-1:0] cr0_q;
    logic                  vm_q;
    logic [VPN_W-1:0]      vpn_q;
    tlb_fill_t             fill_q;
    logic                  flush_q;
    logic [APB_DATA_W-1:0] hit_cnt_q;
    logic [APB_DATA_W-1:0] fault_cnt_q;
    logic                  access;
    logic                  wr_en;
    logic                  reg_hit;
    logic [APB_DATA_W-1:0] rd_data;
    cpu_mode_e             mode;

    assign access = psel & penable;
    assign wr_en  = access & pwrite & reg_hit;

    assign mode = mode_decode(ctrl.pe, ctrl.vm_flag);

    // Address decode and read mux
    always_comb begin
        reg_hit = 1'b1;
        rd_data = '0;
        case (paddr)
            REG_CR0:         rd_data = cr0_q;  // All bits read back
            REG_CTRL:        rd_data[CTRL_VM_BIT] = vm_q;
            REG_TLB_VPN:     rd_data[VPN_W-1:0] = vpn_q;
            REG_TLB_PFN:     rd_data[PFN_W-1:0] = fill_q.pfn;
            REG_STATUS: begin
                rd_data[ST_MODE_LSB +: 3] = mode;
                rd_data[ST_PG_BIT]        = ctrl.pg;
                rd_data[ST_PE_BIT]        = ctrl.pe;
                rd_data[ST_V86_BIT]       = (mode == CPU_MODE_V86);
            end
            REG_HIT_COUNT:   rd_data = hit_cnt_q;
            REG_FAULT_COUNT: rd_data = fault_cnt_q;
            default:         reg_hit = 1'b0;
        endcase
    end

    assign prdata  = rd_data;
    assign pready  = 1'b1;             // Zero wait states
    assign pslverr = access & ~reg_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cr0_q   <= '0;
            vm_q    <= 1'b0;
            vpn_q   <= '0;
            fill_q  <= '0;
            flush_q <= 1'b0;
        end else begin
            fill_q.valid <= 1'b0;
            flush_q      <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    REG_CR0: cr0_q <= pwdata;
                    REG_CTRL: begin
                        vm_q    <= pwdata[CTRL_VM_BIT];
                        flush_q <= pwdata[CTRL_FLUSH_BIT];
                    end
                    REG_TLB_VPN: vpn_q <= pwdata[VPN_W-1:0];
                    REG_TLB_PFN: begin
                        fill_q.valid <= 1'b1;
                        fill_q.vpn   <= vpn_q;
                        fill_q.pfn   <= pwdata[PFN_W-1:0];
                    end
                    default: ;  // Read-only registers ignore writes
                endcase
            end
        end
    end

    // Performance counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_cnt_q   <= '0;
            fault_cnt_q <= '0;
        end else begin
            if (tlb_hit) begin
                hit_cnt_q <= hit_cnt_q + 1'b1;
            end
            if (rsp_valid && rsp.page_fault) begin
                fault_cnt_q <= fault_cnt_q + 1'b1;
            end
        end
    end

    assign ctrl.pe      = cr0_q[CR0_PE_BIT];
    assign ctrl.pg      = cr0_q[CR0_PG_BIT];
    assign ctrl.vm_flag = vm_q;
    assign fill         = fill_q;
    assign flush        = flush_q;

    a_ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable) |-> pready);

endmodule

// File: src/seg_check_stage.sv
// Stage one of translation with mode decode, descriptor parse and privilege check
`include "mmu_config.svh"

module seg_check_stage
    import x86_arch_pkg::*;
    import mmu_regs_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  mmu_ctrl_t  ctrl,
    input  logic       req_valid,
    input  xlate_req_t req,
    output logic       mid_valid,
    output mid_xlate_t mid
);

    seg_info_t seg_d;
    logic      paging_d;

    always_comb begin
        // Flat 1 MiB segment unless protected
        seg_d.mode                = mode_decode(ctrl.pe, ctrl.vm_flag);
        seg_d.base                = '0;
        seg_d.limit               = REAL_MODE_LIMIT;
        seg_d.seg_type            = '0;
        seg_d.segment_valid       = 1'b1;
        seg_d.privilege_violation = 1'b0;

        if (seg_d.mode == CPU_MODE_PROT) begin
            seg_d.base = {req.desc.base_hi, req.desc.base_mid, req.desc.base_lo};
            // Granularity is not applied, limit stays byte sized
            seg_d.limit = `MMU_ADDR_W'({req.desc.limit_hi, req.desc.limit_lo});
            seg_d.seg_type      = req.desc.seg_type;
            seg_d.segment_valid = req.desc.present;
            seg_d.privilege_violation = (req.cpl > req.desc.dpl);
        end
    end

    // No paging in real or v86 mode
    assign paging_d = (seg_d.mode == CPU_MODE_PROT) && ctrl.pg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_valid <= 1'b0;
        end else begin
            mid_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            mid.seg    <= seg_d;
            mid.linear <= req.linear;
            mid.paging <= paging_d;
        end
    end

    a_no_long_mode: assert property (@(posedge clk) disable iff (!rst_n)
        mid_valid |-> (mid.seg.mode != CPU_MODE_LONG));

endmodule

// File: src/page_xlate_stage.sv
// Stage two of translation with direct-mapped TLB, fill, flush and final address
`include "mmu_config.svh"

module page_xlate_stage
    import x86_arch_pkg::*;
    import mmu_regs_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       mid_valid,
    input  mid_xlate_t mid,
    input  tlb_fill_t  fill,
    input  logic       flush,
    output logic       rsp_valid,
    output xlate_rsp_t rsp,
    output logic       tlb_hit
);

    localparam int IDX_W = $clog2(`MMU_TLB_ENTRIES);

    logic [`MMU_TLB_ENTRIES-1:0] tlb_valid;
    logic [VPN_W-1:0]            tlb_tag [`MMU_TLB_ENTRIES];
    logic [PFN_W-1:0]            tlb_pfn [`MMU_TLB_ENTRIES];
    logic [IDX_W-1:0]            fill_idx;
    logic [VPN_W-1:0]            lkp_vpn;
    logic [IDX_W-1:0]            lkp_idx;
    logic                        lkp_hit;
    xlate_rsp_t                  rsp_d;

    assign fill_idx = fill.vpn[IDX_W-1:0];

    // Full VPN is kept as tag, index bits included
    assign lkp_vpn = mid.linear[`MMU_ADDR_W-1:`MMU_PAGE_OFS_W];
    assign lkp_idx = lkp_vpn[IDX_W-1:0];
    assign lkp_hit = tlb_valid[lkp_idx] && (tlb_tag[lkp_idx] == lkp_vpn);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tlb_valid <= '0;
        end else begin
            if (flush) begin
                tlb_valid <= '0;
            end
            if (fill.valid) begin
                tlb_valid[fill_idx] <= 1'b1;  // Overwrites any older mapping
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill.valid) begin
            tlb_tag[fill_idx] <= fill.vpn;
            tlb_pfn[fill_idx] <= fill.pfn;
        end
    end

    always_comb begin
        rsp_d.seg        = mid.seg;
        rsp_d.phys_addr  = mid.linear;  // Identity when paging is off
        rsp_d.page_fault = 1'b0;
        if (mid.paging) begin
            if (lkp_hit) begin
                rsp_d.phys_addr = {tlb_pfn[lkp_idx], mid.linear[`MMU_PAGE_OFS_W-1:0]};
            end else begin
                // No table walk, software must refill
                rsp_d.page_fault = 1'b1;
                rsp_d.phys_addr  = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            tlb_hit   <= 1'b0;
        end else begin
            rsp_valid <= mid_valid;
            tlb_hit   <= mid_valid & mid.paging & lkp_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (mid_valid) begin
            rsp <= rsp_d;
        end
    end

    a_fault_zero_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && rsp.page_fault) |-> (rsp.phys_addr == '0));

endmodule

// File: src/mmu_top.sv
// MMU top level joining the APB register block and both translation stages
`include "mmu_config.svh"

module mmu_top
    import x86_arch_pkg::*;
    import mmu_regs_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`MMU_APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0]      pwdata,
    output logic [APB_DATA_W-1:0]      prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  logic                       req_valid,
    input  xlate_req_t                 req,
    output logic                       rsp_valid,
    output xlate_rsp_t                 rsp
);

    mmu_ctrl_t  ctrl;
    tlb_fill_t  fill;
    logic       flush;
    logic       mid_valid;
    mid_xlate_t mid;
    logic       tlb_hit;

    mmu_csr i_mmu_csr (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .tlb_hit   (tlb_hit),
        .ctrl      (ctrl),
        .fill      (fill),
        .flush     (flush)
    );

    seg_check_stage i_seg_check_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .req_valid (req_valid),
        .req       (req),
        .mid_valid (mid_valid),
        .mid       (mid)
    );

    page_xlate_stage i_page_xlate_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .mid_valid (mid_valid),
        .mid       (mid),
        .fill      (fill),
        .flush     (flush),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .tlb_hit   (tlb_hit)
    );

endmodule

// File: sim/tb_model.svh
// Reference model for CPU mode, descriptor fields and the TLB shadow
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic        shadow_valid [`MMU_TLB_ENTRIES];
logic [19:0] shadow_tag   [`MMU_TLB_ENTRIES];
logic [19:0] shadow_pfn   [`MMU_TLB_ENTRIES];
int          model_hits;
int          model_faults;

task automatic model_flush();
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
        shadow_valid[i] = 1'b0;
    end
endtask

// Direct mapped, slot picked by the low four VPN bits
task automatic model_fill(input logic [19:0] vpn, input logic [19:0] pfn);
    shadow_valid[vpn[3:0]] = 1'b1;
    shadow_tag[vpn[3:0]]   = vpn;
    shadow_pfn[vpn[3:0]]   = pfn;
endtask

// Expected response for one request under the given control bits
task automatic predict_rsp(input logic pe, input logic pg, input logic vm,
                           input xlate_req_t r, output xlate_rsp_t e);
    logic [63:0] d;
    logic [3:0]  idx;
    d   = r.desc;
    idx = r.linear[15:12];
    e   = '0;
    e.seg.limit         = 32'h000F_FFFF;  // 1 MiB flat window
    e.seg.segment_valid = 1'b1;
    e.phys_addr         = r.linear;
    if (!pe) begin
        e.seg.mode = CPU_MODE_REAL;
    end else if (vm) begin
        e.seg.mode = CPU_MODE_V86;
    end else begin
        e.seg.mode                = CPU_MODE_PROT;
        e.seg.base                = {d[63:56], d[39:32], d[31:16]};
        e.seg.limit               = {12'h000, d[51:48], d[15:0]};
        e.seg.seg_type            = d[43:40];
        e.seg.segment_valid       = d[47];           // Present bit
        e.seg.privilege_violation = (r.cpl > d[46:45]);
        if (pg) begin
            if (shadow_valid[idx] && shadow_tag[idx] == r.linear[31:12]) begin
                e.phys_addr = {shadow_pfn[idx], r.linear[11:0]};
                model_hits++;
            end else begin
                e.phys_addr  = '0;
                e.page_fault = 1'b1;
                model_faults++;
            end
        end
    end
endtask

`endif

// File: sim/tb_mmu_top.sv
// Testbench for the MMU with LCG stimulus, reference model checks and a watchdog
`include "mmu_config.svh"

module tb_mmu_top
    import x86_arch_pkg::*;
    import mmu_regs_pkg::*;
();

    localparam int CLK_PERIOD     = 20;
    localparam int TRAFFIC_CYCLES = 48;
    localparam int NUM_FILLS      = 12;
    // Traffic windows plus APB transfers at two cycles each, idle gaps and drains
    localparam int PLAN_CYCLES = 16 + 6 * TRAFFIC_CYCLES + 2 * (2 * NUM_FILLS + 12) + 40;
    localparam int WATCHDOG_CYCLES = PLAN_CYCLES + 100;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        req_valid;
    xlate_req_t  req;
    logic        rsp_valid;
    xlate_rsp_t  rsp;

    logic [31:0] rng_state = 32'd89534;
    int          errors = 0;
    int          cycle = 0;
    logic        m_pe;
    logic        m_pg;
    logic        m_vm;
    xlate_rsp_t  exp_q[$];
    int          due_q[$];
    logic [19:0] vpn_pool [8];
    xlate_rsp_t  mon_exp;
    int          mon_due;

    `include "tb_model.svh"

    mmu_top i_mmu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Halves swapped so low bits are usable for small choices
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        next_cycle();
        penable = 1'b1;     // Access phase with no wait states
        @(negedge clk);
        check_value("pready", 64'd1, pready);
        rdata = prdata;
        err   = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        check_value("pslverr", 64'd0, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'h0, data, err);
        check_value("pslverr", 64'd0, err);
    endtask

    task automatic set_cr0(input logic [31:0] data);
        apb_write(REG_CR0, data);
        m_pe = data[0];
        m_pg = data[31];
    endtask

    task automatic set_ctrl(input logic [31:0] data);
        apb_write(REG_CTRL, data);
        m_vm = data[0];
        if (data[1]) begin
            model_flush();
        end
    endtask

    // Pool addresses three times in four when asked
    task automatic make_request(input logic use_pool, output xlate_req_t r);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] s;
        a = next_random();
        b = next_random();
        c = next_random();
        s = next_random();
        r.linear = a;
        r.desc   = {b, c};
        r.cpl    = s[1:0];
        if (use_pool && s[3:2] != 2'b00) begin
            r.linear[31:12] = vpn_pool[s[6:4]];
        end
    endtask

    task automatic run_traffic(input int n, input logic use_pool);
        xlate_req_t  r;
        xlate_rsp_t  e;
        logic [31:0] s;
        for (int i = 0; i < n; i++) begin
            s = next_random();
            if (s[1:0] != 2'b00) begin
                make_request(use_pool, r);
                predict_rsp(m_pe, m_pg, m_vm, r, e);
                exp_q.push_back(e);
                due_q.push_back(cycle + 2);  // Two edges after the drive
                req       = r;
                req_valid = 1'b1;
            end else begin
                req_valid = 1'b0;
            end
            next_cycle();
        end
        req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    // Response monitor sampled away from the active edge
    always @(negedge clk) begin
        if (rst_n && rsp_valid) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Response at %0t arrived with no request outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                mon_exp = exp_q.pop_front();
                mon_due = due_q.pop_front();
                check_value("rsp_valid cycle", mon_due, cycle);
                check_value("rsp.seg.mode", mon_exp.seg.mode, rsp.seg.mode);
                check_value("rsp.seg.base", mon_exp.seg.base, rsp.seg.base);
                check_value("rsp.seg.limit", mon_exp.seg.limit, rsp.seg.limit);
                check_value("rsp.seg.seg_type", mon_exp.seg.seg_type, rsp.seg.seg_type);
                check_value("rsp.seg.segment_valid", mon_exp.seg.segment_valid,
                            rsp.seg.segment_valid);
                check_value("rsp.seg.privilege_violation", mon_exp.seg.privilege_violation,
                            rsp.seg.privilege_violation);
                check_value("rsp.phys_addr", mon_exp.phys_addr, rsp.phys_addr);
                check_value("rsp.page_fault", mon_exp.page_fault, rsp.page_fault);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles, errors: %0d",
                 WATCHDOG_CYCLES, errors);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] s;
        logic [31:0] exp_status;
        logic [19:0] vpn;
        logic [19:0] pfn;
        logic        err;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        req_valid = 1'b0;
        req       = '0;
        m_pe      = 1'b0;
        m_pg      = 1'b0;
        m_vm      = 1'b0;
        model_hits   = 0;
        model_faults = 0;
        model_flush();
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (2) next_cycle();

        run_traffic(TRAFFIC_CYCLES, 1'b0);  // Real mode out of reset

        // Protected mode where spare CR0 bits must read back
        set_cr0(32'h0000_0031);
        apb_read(REG_CR0, rd);
        check_value("prdata CR0", 32'h0000_0031, rd);
        repeat (2) next_cycle();
        run_traffic(TRAFFIC_CYCLES, 1'b0);

        // Virtual 8086
        set_ctrl(32'h0000_0001);
        exp_status = (32'd2 << ST_MODE_LSB) | (32'd1 << ST_PE_BIT) | (32'd1 << ST_V86_BIT);
        apb_read(REG_STATUS, rd);
        check_value("prdata STATUS", exp_status, rd);
        repeat (2) next_cycle();
        run_traffic(TRAFFIC_CYCLES, 1'b0);

        // Paging on with paired VPNs sharing a slot under different tags
        set_ctrl(32'h0000_0000);
        set_cr0(32'h8000_0001);
        for (int i = 0; i < 4; i++) begin
            s = next_random();
            vpn_pool[i]     = s[19:0];
            vpn_pool[i + 4] = s[19:0] ^ 20'h01000;
        end
        for (int i = 0; i < NUM_FILLS; i++) begin
            s   = next_random();
            vpn = vpn_pool[s[2:0]];
            pfn = s[31:12];
            apb_write(REG_TLB_VPN, {12'h000, vpn});
            apb_write(REG_TLB_PFN, {12'h000, pfn});
            model_fill(vpn, pfn);
        end
        repeat (2) next_cycle();
        run_traffic(2 * TRAFFIC_CYCLES, 1'b1);

        // After a flush every pool address faults
        set_ctrl(32'h0000_0002);
        repeat (2) next_cycle();
        run_traffic(TRAFFIC_CYCLES, 1'b1);

        apb_read(REG_HIT_COUNT, rd);
        check_value("prdata HIT_COUNT", model_hits, rd);
        apb_read(REG_FAULT_COUNT, rd);
        check_value("prdata FAULT_COUNT", model_faults, rd);

        // Unmapped offsets error out and leave CR0 alone
        apb_access(1'b1, 8'h20, 32'hFFFF_FFFF, rd, err);
        check_value("pslverr", 64'd1, err);
        apb_access(1'b0, 8'h1C, 32'h0, rd, err);
        check_value("pslverr", 64'd1, err);
        apb_read(REG_CR0, rd);
        check_value("prdata CR0", 32'h8000_0001, rd);

        assert (exp_q.size() == 0) else begin
            errors++;
            $display("Run ended with %0d responses still missing", exp_q.size());
        end

        $display("Run complete at %0t, hits %0d, faults %0d, errors %0d",
                 $time, model_hits, model_faults, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+src
+incdir+sim
src/x86_arch_pkg.sv
src/mmu_regs_pkg.sv
src/mmu_csr.sv
src/seg_check_stage.sv
src/page_xlate_stage.sv
src/mmu_top.sv
sim/tb_mmu_top.sv

// File: Makefile
TOP := tb_mmu_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
